// File: verilog/ht_params.svh
// widths assume 32-bit keys and one 32-bit header per slot, so a bucket line is 256 bits
`ifndef HT_PARAMS_SVH
`define HT_PARAMS_SVH

// --------------------------------------------------------------------------
// key and header fields
// --------------------------------------------------------------------------

// key zero is reserved and marks an empty slot
`define HT_KEY_W 32

// value length in bytes
`define HT_PLEN_W 11

// value pointer handed out by the allocator
`define HT_PADDR_W 21

// --------------------------------------------------------------------------
// bucket geometry
// --------------------------------------------------------------------------

`define HT_SLOTS 4
`define HT_MADDR_W 10

// sizes are compared in granules of this many bytes
`define HT_LEN_ROUND 8

`endif

// File: verilog/ht_pkg.sv
// shared types for the write stage; field layout of a slot is key in the upper word, header below
`include "ht_params.svh"

package ht_pkg;

	typedef enum logic [3:0] {
		op_get    = 4'd0,
		op_set    = 4'd1,
		op_delete = 4'd2
	} opcode_e;

	typedef enum logic [1:0] {
		st_ok         = 2'd0,
		st_not_found  = 2'd1,
		st_table_full = 2'd2
	} status_e;

	typedef enum logic [2:0] {
		upd_idle,
		upd_decide,
		upd_wait_alloc,
		upd_write,
		upd_respond
	} upd_state_e;

	typedef logic [$clog2(`HT_SLOTS)-1:0] slot_idx_t;

	// ----------------------------------------------------------------------
	// memory line layout
	// ----------------------------------------------------------------------

	typedef struct packed {
		logic [`HT_PLEN_W-1:0]  len;
		logic [`HT_PADDR_W-1:0] ptr;
	} header_t;

	typedef struct packed {
		logic [`HT_KEY_W-1:0] key;
		header_t              hdr;
	} slot_t;

	typedef slot_t [`HT_SLOTS-1:0] line_t;

	// ----------------------------------------------------------------------
	// streams
	// ----------------------------------------------------------------------

	typedef struct packed {
		opcode_e                opcode;
		logic [`HT_KEY_W-1:0]   key;
		logic [`HT_PLEN_W-1:0]  len;
		logic [`HT_MADDR_W-1:0] hash1;
		logic [`HT_MADDR_W-1:0] hash2;
	} request_t;

	typedef struct packed {
		logic [`HT_PADDR_W-1:0] ptr;
		logic [`HT_PLEN_W-1:0]  len;
	} free_t;

	typedef struct packed {
		logic [`HT_KEY_W-1:0] key;
		opcode_e              opcode;
		status_e              status;
		header_t              hdr;
	} response_t;

	// found wins over avail; addr, idx and line describe the target slot
	typedef struct packed {
		request_t               req;
		logic                   found;
		logic                   avail;
		logic [`HT_MADDR_W-1:0] addr;
		slot_idx_t              idx;
		line_t                  line;
	} lookup_t;

endpackage

// File: verilog/ht_bucket_match.sv
// purely combinational; a zero key never reports a hit, and the lowest slot index wins
`timescale 1ns/100ps
`include "ht_params.svh"

module ht_bucket_match
	import ht_pkg::*;
(
	input  line_t                line,
	input  logic [`HT_KEY_W-1:0] key,
	output logic                 hit,
	output slot_idx_t            hit_idx,
	output logic                 has_empty,
	output slot_idx_t            empty_idx
);

	// walk downward so the lowest matching slot is the last one assigned
	always_comb begin
		hit       = 1'b0;
		hit_idx   = '0;
		has_empty = 1'b0;
		empty_idx = '0;
		for (int i = `HT_SLOTS - 1; i >= 0; i--) begin
			if (line[i].key == key && key != '0) begin
				hit     = 1'b1;
				hit_idx = slot_idx_t'(i);
			end
			if (line[i].key == '0) begin
				has_empty = 1'b1;
				empty_idx = slot_idx_t'(i);
			end
		end
	end

endmodule

// File: verilog/ht_lookup.sv
// holds one request at a time; memory must return the hash1 line first, then the hash2 line
`timescale 1ns/100ps
`include "ht_params.svh"

module ht_lookup
	import ht_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  request_t req,
	input  logic     req_valid,
	output logic     req_ready,
	input  line_t    rd_data,
	input  logic     rd_valid,
	output logic     rd_ready,
	output lookup_t  look,
	output logic     look_valid,
	input  logic     look_ready
);

	typedef enum logic [1:0] {
		lk_idle,
		lk_rd1,
		lk_rd2,
		lk_out
	} lk_state_e;

	lk_state_e state;
	request_t  req_q;
	line_t     line1;
	line_t     line2;

	logic      hit1, hit2;
	logic      empty1, empty2;
	slot_idx_t hit_idx1, hit_idx2;
	slot_idx_t empty_idx1, empty_idx2;

	// --------------------------------------------------------------------------
	// request capture and the two read beats
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= lk_idle;
			req_ready  <= 1'b0;
			rd_ready   <= 1'b0;
			look_valid <= 1'b0;
		end else begin
			case (state)
				lk_idle: begin
					req_ready <= 1'b1;
					if (req_valid && req_ready) begin
						req_q     <= req;
						req_ready <= 1'b0;
						rd_ready  <= 1'b1;
						state     <= lk_rd1;
					end
				end
				lk_rd1: begin
					if (rd_valid && rd_ready) begin
						line1 <= rd_data;
						state <= lk_rd2;
					end
				end
				lk_rd2: begin
					if (rd_valid && rd_ready) begin
						line2      <= rd_data;
						rd_ready   <= 1'b0;
						look_valid <= 1'b1;
						state      <= lk_out;
					end
				end
				default: begin
					if (look_ready) begin
						look_valid <= 1'b0;
						state      <= lk_idle;
					end
				end
			endcase
		end
	end

	ht_bucket_match u_match1 (
		.line      (line1),
		.key       (req_q.key),
		.hit       (hit1),
		.hit_idx   (hit_idx1),
		.has_empty (empty1),
		.empty_idx (empty_idx1)
	);

	ht_bucket_match u_match2 (
		.line      (line2),
		.key       (req_q.key),
		.hit       (hit2),
		.hit_idx   (hit_idx2),
		.has_empty (empty2),
		.empty_idx (empty_idx2)
	);

	// a hit anywhere beats a free slot; hash1 beats hash2 at each level
	always_comb begin
		look.req   = req_q;
		look.found = 1'b0;
		look.avail = 1'b0;
		look.addr  = req_q.hash1;
		look.idx   = '0;
		look.line  = line1;
		if (hit1) begin
			look.found = 1'b1;
			look.idx   = hit_idx1;
		end else if (hit2) begin
			look.found = 1'b1;
			look.addr  = req_q.hash2;
			look.idx   = hit_idx2;
			look.line  = line2;
		end else if (empty1) begin
			look.avail = 1'b1;
			look.idx   = empty_idx1;
		end else if (empty2) begin
			look.avail = 1'b1;
			look.addr  = req_q.hash2;
			look.idx   = empty_idx2;
			look.line  = line2;
		end
	end

endmodule

// File: verilog/ht_update.sv
// one lookup record at a time; a new write waits until the previous write-back and free are taken
`timescale 1ns/100ps
`include "ht_params.svh"

module ht_update
	import ht_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  lookup_t                look,
	input  logic                   look_valid,
	output logic                   look_ready,
	output logic [15:0]            alloc_req_size,
	output logic                   alloc_req_valid,
	input  logic                   alloc_req_ready,
	input  logic [`HT_PADDR_W-1:0] alloc_ptr,
	input  logic                   alloc_valid,
	output logic                   alloc_ready,
	output free_t                  free,
	output logic                   free_valid,
	input  logic                   free_ready,
	output line_t                  wr_data,
	output logic                   wr_valid,
	input  logic                   wr_ready,
	output logic [`HT_MADDR_W-1:0] wrcmd_addr,
	output logic                   wrcmd_valid,
	input  logic                   wrcmd_ready,
	output response_t              resp,
	output logic                   resp_valid,
	input  logic                   resp_ready
);

	upd_state_e state;
	lookup_t    cur;
	slot_t      new_slot;
	header_t    old_hdr;
	line_t      merged;
	logic       same_size;

	// length rounded up to whole granules
	function automatic logic [`HT_PLEN_W:0] granules(input logic [`HT_PLEN_W-1:0] len);
		return ({1'b0, len} + (`HT_LEN_ROUND - 1)) / `HT_LEN_ROUND;
	endfunction

	assign old_hdr     = cur.line[cur.idx].hdr;
	assign same_size   = granules(old_hdr.len) == granules(cur.req.len);
	assign alloc_ready = (state == upd_wait_alloc);

	always_comb begin
		merged          = cur.line;
		merged[cur.idx] = new_slot;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state           <= upd_idle;
			look_ready      <= 1'b0;
			alloc_req_valid <= 1'b0;
			free_valid      <= 1'b0;
			wr_valid        <= 1'b0;
			wrcmd_valid     <= 1'b0;
			resp_valid      <= 1'b0;
		end else begin
			// ------------------------------------------------------------------
			// each output stream drops valid on its own transfer
			// ------------------------------------------------------------------
			if (alloc_req_valid && alloc_req_ready)
				alloc_req_valid <= 1'b0;
			if (free_valid && free_ready)
				free_valid <= 1'b0;
			if (wr_valid && wr_ready)
				wr_valid <= 1'b0;
			if (wrcmd_valid && wrcmd_ready)
				wrcmd_valid <= 1'b0;
			if (resp_valid && resp_ready)
				resp_valid <= 1'b0;

			case (state)
				upd_idle: begin
					if (look_valid && look_ready) begin
						cur        <= look;
						look_ready <= 1'b0;
						state      <= upd_decide;
					end else begin
						look_ready <= 1'b1;
					end
				end

				upd_decide: begin
					resp.key    <= cur.req.key;
					resp.opcode <= cur.req.opcode;
					resp.status <= st_ok;
					resp.hdr    <= old_hdr;
					new_slot    <= '{key: cur.req.key, hdr: old_hdr};
					case (cur.req.opcode)
						op_set: begin
							if (cur.found && same_size) begin
								state <= upd_write;
							end else if (cur.found || cur.avail) begin
								// resized value gives its old block back first
								if (cur.found) begin
									free       <= '{ptr: old_hdr.ptr, len: old_hdr.len};
									free_valid <= 1'b1;
								end
								alloc_req_size  <= 16'(cur.req.len);
								alloc_req_valid <= 1'b1;
								state           <= upd_wait_alloc;
							end else begin
								resp.status <= st_table_full;
								resp.hdr    <= '0;
								resp_valid  <= 1'b1;
								state       <= upd_respond;
							end
						end
						op_delete: begin
							if (cur.found) begin
								new_slot   <= '0;
								free       <= '{ptr: old_hdr.ptr, len: old_hdr.len};
								free_valid <= 1'b1;
								state      <= upd_write;
							end else begin
								resp.status <= st_not_found;
								resp.hdr    <= '0;
								resp_valid  <= 1'b1;
								state       <= upd_respond;
							end
						end
						default: begin
							// get, answered straight from the lookup
							if (!cur.found) begin
								resp.status <= st_not_found;
								resp.hdr    <= '0;
							end
							resp_valid <= 1'b1;
							state      <= upd_respond;
						end
					endcase
				end

				upd_wait_alloc: begin
					if (alloc_valid) begin
						new_slot.hdr <= '{len: cur.req.len, ptr: alloc_ptr};
						resp.hdr     <= '{len: cur.req.len, ptr: alloc_ptr};
						state        <= upd_write;
					end
				end

				upd_write: begin
					if (!wr_valid && !wrcmd_valid && !free_valid) begin
						wr_data     <= merged;
						wr_valid    <= 1'b1;
						wrcmd_addr  <= cur.addr;
						wrcmd_valid <= 1'b1;
						resp_valid  <= 1'b1;
						state       <= upd_respond;
					end
				end

				upd_respond: begin
					if (resp_valid && resp_ready)
						state <= upd_idle;
				end

				default: state <= upd_idle;
			endcase
		end
	end

endmodule

// File: verilog/ht_write_top.sv
// no pipelining; a request is taken only after the previous lookup record has moved on
`timescale 1ns/100ps
`include "ht_params.svh"

module ht_write_top
	import ht_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,

	input  request_t               req,
	input  logic                   req_valid,
	output logic                   req_ready,

	input  line_t                  rd_data,
	input  logic                   rd_valid,
	output logic                   rd_ready,

	output line_t                  wr_data,
	output logic                   wr_valid,
	input  logic                   wr_ready,
	output logic [`HT_MADDR_W-1:0] wrcmd_addr,
	output logic                   wrcmd_valid,
	input  logic                   wrcmd_ready,

	output logic [15:0]            alloc_req_size,
	output logic                   alloc_req_valid,
	input  logic                   alloc_req_ready,
	input  logic [`HT_PADDR_W-1:0] alloc_ptr,
	input  logic                   alloc_valid,
	output logic                   alloc_ready,

	output free_t                  free,
	output logic                   free_valid,
	input  logic                   free_ready,

	output response_t              resp,
	output logic                   resp_valid,
	input  logic                   resp_ready
);

	lookup_t look;
	logic    look_valid;
	logic    look_ready;

	ht_lookup u_lookup (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid),
		.rd_ready   (rd_ready),
		.look       (look),
		.look_valid (look_valid),
		.look_ready (look_ready)
	);

	ht_update u_update (
		.clk             (clk),
		.rst             (rst),
		.look            (look),
		.look_valid      (look_valid),
		.look_ready      (look_ready),
		.alloc_req_size  (alloc_req_size),
		.alloc_req_valid (alloc_req_valid),
		.alloc_req_ready (alloc_req_ready),
		.alloc_ptr       (alloc_ptr),
		.alloc_valid     (alloc_valid),
		.alloc_ready     (alloc_ready),
		.free            (free),
		.free_valid      (free_valid),
		.free_ready      (free_ready),
		.wr_data         (wr_data),
		.wr_valid        (wr_valid),
		.wr_ready        (wr_ready),
		.wrcmd_addr      (wrcmd_addr),
		.wrcmd_valid     (wrcmd_valid),
		.wrcmd_ready     (wrcmd_ready),
		.resp            (resp),
		.resp_valid      (resp_valid),
		.resp_ready      (resp_ready)
	);

endmodule

// File: testbench/ht_write_chk.sv
// protocol checks on the top-level streams; the first clock edge in reset is not checked
`timescale 1ns/100ps

module ht_write_chk (
	input logic clk,
	input logic rst,
	input logic req_ready,
	input logic rd_ready,
	input logic wr_valid,
	input logic wr_ready,
	input logic wrcmd_valid,
	input logic wrcmd_ready,
	input logic alloc_req_valid,
	input logic alloc_req_ready,
	input logic alloc_ready,
	input logic free_valid,
	input logic free_ready,
	input logic resp_valid,
	input logic resp_ready
);

	int fail_n = 0;

	property hold_until_ready(v, r);
		@(posedge clk) disable iff (rst) v && !r |=> v;
	endproperty

	// --------------------------------------------------------------------------
	// valid stays up until the transfer
	// --------------------------------------------------------------------------

	a_wr_hold: assert property (hold_until_ready(wr_valid, wr_ready))
		else begin
			fail_n++;
			$error("wr_valid dropped before wr_ready");
		end
	a_wrcmd_hold: assert property (hold_until_ready(wrcmd_valid, wrcmd_ready))
		else begin
			fail_n++;
			$error("wrcmd_valid dropped before wrcmd_ready");
		end
	a_alloc_hold: assert property (hold_until_ready(alloc_req_valid, alloc_req_ready))
		else begin
			fail_n++;
			$error("alloc_req_valid dropped before alloc_req_ready");
		end
	a_free_hold: assert property (hold_until_ready(free_valid, free_ready))
		else begin
			fail_n++;
			$error("free_valid dropped before free_ready");
		end
	a_resp_hold: assert property (hold_until_ready(resp_valid, resp_ready))
		else begin
			fail_n++;
			$error("resp_valid dropped before resp_ready");
		end

	// data and command of a write-back start in the same cycle
	a_wr_pair: assert property (@(posedge clk) disable iff (rst)
		$rose(wr_valid) == $rose(wrcmd_valid))
		else begin
			fail_n++;
			$error("wr_valid and wrcmd_valid rose in different cycles");
		end

	// every handshake output is low once a reset edge has been seen
	a_reset_quiet: assert property (@(posedge clk) $past(rst) |->
		!(req_ready || rd_ready || wr_valid || wrcmd_valid || alloc_req_valid
		|| alloc_ready || free_valid || resp_valid))
		else begin
			fail_n++;
			$error("handshake output high while in reset");
		end

endmodule

// File: testbench/ht_write_tb.sv
// memory and allocator are models; a new request goes out only after the previous write-back landed
`timescale 1ns/100ps
`include "ht_params.svh"

module ht_write_tb
	import ht_pkg::*;
;

	typedef struct {
		string                  name;
		opcode_e                op;
		logic [`HT_KEY_W-1:0]   key;
		logic [`HT_PLEN_W-1:0]  len;
		logic [`HT_MADDR_W-1:0] h1;
		logic [`HT_MADDR_W-1:0] h2;
		status_e                st;
		header_t                hdr;
		logic [`HT_PADDR_W-1:0] free_ptr;
	} entry_t;

	logic                   clk;
	logic                   rst;
	request_t               req;
	logic                   req_valid;
	logic                   req_ready;
	line_t                  rd_data;
	logic                   rd_valid;
	logic                   rd_ready;
	line_t                  wr_data;
	logic                   wr_valid;
	logic                   wr_ready;
	logic [`HT_MADDR_W-1:0] wrcmd_addr;
	logic                   wrcmd_valid;
	logic                   wrcmd_ready;
	logic [15:0]            alloc_req_size;
	logic                   alloc_req_valid;
	logic                   alloc_req_ready;
	logic [`HT_PADDR_W-1:0] alloc_ptr;
	logic                   alloc_valid;
	logic                   alloc_ready;
	free_t                  free;
	logic                   free_valid;
	logic                   free_ready;
	response_t              resp;
	logic                   resp_valid;
	logic                   resp_ready;

	line_t                  mem [0:(1 << `HT_MADDR_W) - 1];
	line_t                  rd_q [$];
	entry_t                 tbl [$];
	logic                   rd_gap;
	line_t                  wr_line;
	logic [`HT_MADDR_W-1:0] wr_addr;
	logic                   wr_line_ok;
	logic                   wr_addr_ok;
	logic [`HT_PADDR_W-1:0] next_ptr;
	logic [`HT_PADDR_W-1:0] last_free;
	logic [15:0]            alloc_size;
	int                     writes_n;
	int                     allocs_n;
	int                     frees_n;
	int                     checks_n;
	int                     errors;

	ht_write_top uut (
		.clk             (clk),
		.rst             (rst),
		.req             (req),
		.req_valid       (req_valid),
		.req_ready       (req_ready),
		.rd_data         (rd_data),
		.rd_valid        (rd_valid),
		.rd_ready        (rd_ready),
		.wr_data         (wr_data),
		.wr_valid        (wr_valid),
		.wr_ready        (wr_ready),
		.wrcmd_addr      (wrcmd_addr),
		.wrcmd_valid     (wrcmd_valid),
		.wrcmd_ready     (wrcmd_ready),
		.alloc_req_size  (alloc_req_size),
		.alloc_req_valid (alloc_req_valid),
		.alloc_req_ready (alloc_req_ready),
		.alloc_ptr       (alloc_ptr),
		.alloc_valid     (alloc_valid),
		.alloc_ready     (alloc_ready),
		.free            (free),
		.free_valid      (free_valid),
		.free_ready      (free_ready),
		.resp            (resp),
		.resp_valid      (resp_valid),
		.resp_ready      (resp_ready)
	);

	bind ht_write_top ht_write_chk u_chk (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------------------------------------------------------------
	// memory model: writes land first, then the two lines of a new request are queued
	// --------------------------------------------------------------------------

	always @(posedge clk) begin : mem_model
		logic took;
		logic gap;
		took = rd_valid && rd_ready;
		gap  = rd_gap;
		// data and command may be taken in different cycles
		if (wr_valid && wr_ready) begin
			wr_line    = wr_data;
			wr_line_ok = 1'b1;
		end
		if (wrcmd_valid && wrcmd_ready) begin
			wr_addr    = wrcmd_addr;
			wr_addr_ok = 1'b1;
		end
		if (wr_line_ok && wr_addr_ok) begin
			mem[wr_addr] = wr_line;
			wr_line_ok   = 1'b0;
			wr_addr_ok   = 1'b0;
			writes_n++;
		end
		if (req_valid && req_ready) begin
			rd_q.push_back(mem[req.hash1]);
			rd_q.push_back(mem[req.hash2]);
		end
		#1;
		if (took)
			rd_valid = 1'b0;
		if (!rd_valid && !gap && rd_q.size() > 0) begin
			rd_data  = rd_q.pop_front();
			rd_valid = 1'b1;
		end
	end

	// allocator hands out 0x100, 0x140, 0x180 and so on
	always @(posedge clk) begin : alloc_model
		logic asked;
		asked = alloc_req_valid && alloc_req_ready;
		if (alloc_valid && alloc_ready) begin
			next_ptr = next_ptr + 'h40;
			allocs_n++;
			#1;
			alloc_valid = 1'b0;
		end else if (asked) begin
			alloc_size = alloc_req_size;
			#1;
			alloc_ptr   = next_ptr;
			alloc_valid = 1'b1;
		end
	end

	always @(posedge clk) begin : free_model
		if (free_valid && free_ready) begin
			frees_n++;
			last_free = free.ptr;
		end
	end

	task automatic add_entry(input string name, input opcode_e op, input logic [31:0] key,
		input logic [31:0] len, input logic [31:0] h1, input logic [31:0] h2,
		input status_e st, input logic [31:0] hlen, input logic [31:0] hptr,
		input logic [31:0] fptr);
		entry_t e;
		e.name     = name;
		e.op       = op;
		e.key      = key[`HT_KEY_W-1:0];
		e.len      = len[`HT_PLEN_W-1:0];
		e.h1       = h1[`HT_MADDR_W-1:0];
		e.h2       = h2[`HT_MADDR_W-1:0];
		e.st       = st;
		e.hdr.len  = hlen[`HT_PLEN_W-1:0];
		e.hdr.ptr  = hptr[`HT_PADDR_W-1:0];
		e.free_ptr = fptr[`HT_PADDR_W-1:0];
		tbl.push_back(e);
	endtask

	// full line of keys base_key+i, each 16 bytes at base_ptr+i
	task automatic preload_line(input int addr, input int base_key, input int base_ptr);
		for (int i = 0; i < `HT_SLOTS; i++) begin
			mem[addr][i].key     = `HT_KEY_W'(base_key + i);
			mem[addr][i].hdr.len = `HT_PLEN_W'(16);
			mem[addr][i].hdr.ptr = `HT_PADDR_W'(base_ptr + i);
		end
	endtask

	task automatic check_value(input string name, input string what, input logic [63:0] exp,
		input logic [63:0] act);
		checks_n++;
		assert (act === exp)
		else begin
			errors++;
			$display("Fail %s: %s expected %0h, actual %0h", name, what, exp, act);
		end
	endtask

	task automatic run_entry(input entry_t e);
		response_t              got;
		logic [`HT_PADDR_W-1:0] ptr_before;
		int                     exp_writes;
		int                     exp_allocs;
		int                     exp_frees;
		ptr_before = next_ptr;
		writes_n   = 0;
		allocs_n   = 0;
		frees_n    = 0;
		last_free  = '0;
		alloc_size = '0;
		// a write-back follows every successful SET or DELETE
		exp_writes = (e.st == st_ok && e.op != op_get) ? 1 : 0;
		exp_allocs = (e.op == op_set && e.st == st_ok && e.hdr.ptr == ptr_before) ? 1 : 0;
		exp_frees  = (e.free_ptr != '0) ? 1 : 0;
		req.opcode = e.op;
		req.key    = e.key;
		req.len    = e.len;
		req.hash1  = e.h1;
		req.hash2  = e.h2;
		req_valid  = 1'b1;
		@(posedge clk);
		while (!req_ready)
			@(posedge clk);
		#1;
		req_valid = 1'b0;
		@(posedge clk);
		while (!(resp_valid && resp_ready))
			@(posedge clk);
		got = resp;
		// the write-back may still be held off after the response
		while (wr_valid || wrcmd_valid)
			@(posedge clk);
		#1;
		check_value(e.name, "key", e.key, got.key);
		check_value(e.name, "opcode", e.op, got.opcode);
		check_value(e.name, "status", e.st, got.status);
		check_value(e.name, "header", e.hdr, got.hdr);
		check_value(e.name, "frees", exp_frees, frees_n);
		if (exp_frees != 0)
			check_value(e.name, "freed pointer", e.free_ptr, last_free);
		check_value(e.name, "write-backs", exp_writes, writes_n);
		check_value(e.name, "allocations", exp_allocs, allocs_n);
		if (exp_allocs != 0)
			check_value(e.name, "allocation size", e.len, alloc_size);
	endtask

	initial begin : main
		rst             = 1'b1;
		req             = '0;
		req_valid       = 1'b0;
		rd_data         = '0;
		rd_valid        = 1'b0;
		wr_ready        = 1'b1;
		wrcmd_ready     = 1'b1;
		alloc_req_ready = 1'b1;
		alloc_ptr       = '0;
		alloc_valid     = 1'b0;
		free_ready      = 1'b1;
		resp_ready      = 1'b1;
		rd_gap          = 1'b0;
		wr_line_ok      = 1'b0;
		wr_addr_ok      = 1'b0;
		alloc_size      = '0;
		next_ptr        = 'h100;
		checks_n        = 0;
		errors          = 0;
		void'($urandom(32'h003c_10d7));

		for (int a = 0; a < (1 << `HT_MADDR_W); a++)
			mem[a] = '0;
		preload_line(20, 'h200, 'h2000);
		preload_line(30, 'h300, 'h3000);
		preload_line(40, 'h400, 'h4000);

		// ----------------------------------------------------------------------
		// name, op, key, len, hash1, hash2, status, hdr len, hdr ptr, freed ptr
		// ----------------------------------------------------------------------
		add_entry("get_unwritten", op_get, 'h11, 0, 10, 11, st_not_found, 0, 0, 0);
		add_entry("set_new_hash1", op_set, 'h11, 20, 10, 11, st_ok, 20, 'h100, 0);
		add_entry("get_hash1", op_get, 'h11, 0, 10, 11, st_ok, 20, 'h100, 0);
		add_entry("set_new_hash2", op_set, 'h12, 5, 20, 21, st_ok, 5, 'h140, 0);
		add_entry("get_hash2", op_get, 'h12, 0, 20, 21, st_ok, 5, 'h140, 0);
		add_entry("set_same_size", op_set, 'h11, 24, 10, 11, st_ok, 20, 'h100, 0);
		add_entry("set_resize", op_set, 'h11, 40, 10, 11, st_ok, 40, 'h180, 'h100);
		add_entry("get_resized", op_get, 'h11, 0, 10, 11, st_ok, 40, 'h180, 0);
		add_entry("delete_hit", op_delete, 'h11, 0, 10, 11, st_ok, 40, 'h180, 'h180);
		add_entry("get_deleted", op_get, 'h11, 0, 10, 11, st_not_found, 0, 0, 0);
		add_entry("delete_miss", op_delete, 'h11, 0, 10, 11, st_not_found, 0, 0, 0);
		add_entry("set_table_full", op_set, 'h99, 12, 30, 40, st_table_full, 0, 0, 0);
		add_entry("get_preload_h1", op_get, 'h302, 0, 30, 40, st_ok, 16, 'h3002, 0);
		add_entry("delete_hash2", op_delete, 'h12, 0, 20, 21, st_ok, 5, 'h140, 'h140);
		add_entry("set_reuse_slot", op_set, 'h13, 8, 10, 11, st_ok, 8, 'h1c0, 0);
		add_entry("get_preload_h2", op_get, 'h402, 0, 30, 40, st_ok, 16, 'h4002, 0);
		add_entry("set_small", op_set, 'h13, 1, 10, 11, st_ok, 8, 'h1c0, 0);
		add_entry("set_grow_preload", op_set, 'h203, 100, 20, 21, st_ok, 100, 'h200, 'h2003);
		add_entry("get_grown", op_get, 'h203, 0, 20, 21, st_ok, 100, 'h200, 0);

		fork
			// back-pressure and read gaps
			forever begin
				@(posedge clk);
				#1;
				resp_ready      = ($urandom % 4) != 0;
				free_ready      = ($urandom % 3) != 0;
				wr_ready        = ($urandom % 3) != 0;
				wrcmd_ready     = ($urandom % 3) != 0;
				alloc_req_ready = ($urandom % 2) != 0;
				rd_gap          = ($urandom % 4) == 0;
			end
			begin
				repeat (tbl.size() * 200) @(posedge clk);
				$display("timeout: no response after %0d cycles", tbl.size() * 200);
				$display("checks %0d, errors %0d, assertion failures %0d", checks_n, errors,
					uut.u_chk.fail_n);
				$display("ERRORS FOUND");
				$finish;
			end
		join_none

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		foreach (tbl[i])
			run_entry(tbl[i]);

		$display("checks %0d, errors %0d, assertion failures %0d", checks_n, errors,
			uut.u_chk.fail_n);
		if (errors == 0 && uut.u_chk.fail_n == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+verilog
verilog/ht_pkg.sv
verilog/ht_bucket_match.sv
verilog/ht_lookup.sv
verilog/ht_update.sv
verilog/ht_write_top.sv
testbench/ht_write_chk.sv
testbench/ht_write_tb.sv
